// ==== bench/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module exec_core_tb import core_pkg::*; ();

  localparam int unsigned SEED = 32'h40a0_f9a6;
  localparam int READY_LIMIT = 64; // cycles an instruction may wait for instr_ready.
  localparam int DRAIN_LIMIT = 200;

  logic     clk = 1'b0;
  logic     reset;
  logic     instr_valid;
  op_t      instr_op;
  reg_idx_t instr_rd;
  reg_idx_t instr_rs1;
  reg_idx_t instr_rs2;
  imm_t     instr_imm;
  logic     instr_ready;
  logic     commit_valid;
  reg_idx_t commit_rd;
  word_t    commit_value;

  word_t    model_regs[`REG_COUNT]; // architectural state after every accepted instruction.
  reg_idx_t exp_rd_q[$];
  word_t    exp_value_q[$];
  int       check_errors = 0;
  int       commit_errors = 0;
  int       commit_count = 0;
  int       cycle = 0;
  int       accepted;
  int       accept_cycle;
  int       peak_in_flight;
  int       tests_passed;
  int       tests_failed;
  bit       timed_out;

  exec_core dut (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr_op(instr_op),
    .instr_rd(instr_rd), .instr_rs1(instr_rs1), .instr_rs2(instr_rs2),
    .instr_imm(instr_imm), .instr_ready(instr_ready), .commit_valid(commit_valid),
    .commit_rd(commit_rd), .commit_value(commit_value)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // the registered commit outputs are sampled on the falling edge.
  always @(negedge clk) begin
    if (!reset && commit_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("unexpected commit at %0t to r%0d with nothing outstanding", $time, commit_rd);
        commit_errors++;
      end else begin
        if (commit_rd !== exp_rd_q[0]) begin
          $display("** Error at %0t: commit_rd = %0d, expected %0d", $time, commit_rd,
                   exp_rd_q[0]);
          commit_errors++;
        end
        if (commit_value !== exp_value_q[0]) begin
          $display("** Error at %0t: commit_value = %h, expected %h", $time, commit_value,
                   exp_value_q[0]);
          commit_errors++;
        end
        void'(exp_rd_q.pop_front());
        void'(exp_value_q.pop_front());
      end
      if (commit_rd == '0 && commit_value !== '0) begin
        $display("** Error at %0t: commit_value = %h for r0, expected %h", $time,
                 commit_value, 32'h0);
        commit_errors++;
      end
      commit_count++;
    end
  end

  function automatic word_t model_result(op_t op, word_t x, word_t y, imm_t imm);
    word_t sext;
    sext = {{16{imm[15]}}, imm};
    case (op)
      op_li:   return sext;
      op_addi: return x + sext;
      op_add:  return x + y;
      op_sub:  return x - y;
      op_and:  return x & y;
      op_or:   return x | y;
      op_xor:  return x ^ y;
      op_slt:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      op_sll:  return x << y[4:0];
      op_srl:  return x >> y[4:0];
      op_mul:  return x * y; // only the low word of the product survives.
      default: return '0;
    endcase
  endfunction

  function automatic op_t random_alu_op();
    return op_t'(4'($urandom_range(9, 0)));
  endfunction

  function automatic int total_errors();
    return check_errors + commit_errors;
  endfunction

  // presents one instruction and returns at the edge that accepts it.
  task automatic send(input op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                      input reg_idx_t rs2, input imm_t imm, output int idx);
    int    waited;
    word_t value;
    idx = -1;
    if (timed_out) return;
    instr_valid <= 1'b1;
    instr_op    <= op;
    instr_rd    <= rd;
    instr_rs1   <= rs1;
    instr_rs2   <= rs2;
    instr_imm   <= imm;
    waited = 0;
    @(negedge clk);
    while (!instr_ready && waited < READY_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!instr_ready) begin
      $display("timeout: %s to r%0d was not accepted within %0d cycles", op.name(), rd,
               READY_LIMIT);
      timed_out = 1'b1;
      instr_valid <= 1'b0;
      return;
    end
    @(posedge clk);
    value = model_result(op, model_regs[rs1], model_regs[rs2], imm);
    if (rd != '0) model_regs[rd] = value;
    else value = '0; // r0 always commits as zero.
    exp_rd_q.push_back(rd);
    exp_value_q.push_back(value);
    if (exp_rd_q.size() > peak_in_flight) peak_in_flight = exp_rd_q.size();
    idx = accepted;
    accepted++;
    accept_cycle = cycle;
  endtask

  task automatic drain();
    int waited;
    instr_valid <= 1'b0;
    waited = 0;
    if (timed_out) return;
    while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_rd_q.size() != 0) begin
      $display("timeout: %0d instructions never committed", exp_rd_q.size());
      timed_out = 1'b1;
    end
  endtask

  task automatic load_readback();
    int idx;
    for (int r = 0; r < `REG_COUNT; r++) begin
      send(op_li, reg_idx_t'(r), 4'd0, 4'd0, imm_t'($urandom), idx);
    end
    for (int r = 0; r < `REG_COUNT; r++) begin
      send(op_addi, reg_idx_t'(r), reg_idx_t'(r), 4'd0, 16'h0000, idx);
    end
    drain();
  endtask

  task automatic alu_ops();
    int idx;
    send(op_li, 4'd1, 4'd0, 4'd0, 16'hfff9, idx); // -7.
    send(op_li, 4'd2, 4'd0, 4'd0, 16'd37, idx);   // a shift by 37 acts as 5.
    send(op_li, 4'd3, 4'd0, 4'd0, 16'd3, idx);
    send(op_slt, 4'd4, 4'd1, 4'd3, 16'h0000, idx);
    send(op_slt, 4'd5, 4'd3, 4'd1, 16'h0000, idx);
    send(op_sll, 4'd6, 4'd3, 4'd2, 16'h0000, idx);
    send(op_srl, 4'd7, 4'd1, 4'd2, 16'h0000, idx);
    for (int i = 0; i < 60; i++) begin
      send(random_alu_op(), reg_idx_t'($urandom_range(15, 0)),
           reg_idx_t'($urandom_range(15, 0)), reg_idx_t'($urandom_range(15, 0)),
           imm_t'($urandom), idx);
    end
    drain();
  endtask

  task automatic ooo_commit();
    int idx;
    int mul_cycle;
    send(op_mul, 4'd8, 4'd1, 4'd2, 16'h0000, idx);
    mul_cycle = accept_cycle;
    send(op_add, 4'd9, 4'd3, 4'd3, 16'h0000, idx);
    // the alu slot lies ahead of the multiply's, so nothing should hold this one back.
    if (!timed_out && accept_cycle != mul_cycle + 1) begin
      $display("the ALU instruction after the multiply waited %0d extra cycles",
               accept_cycle - mul_cycle - 1);
      check_errors++;
    end
    send(op_xor, 4'd10, 4'd2, 4'd3, 16'h0000, idx);
    send(op_or, 4'd11, 4'd1, 4'd3, 16'h0000, idx);
    send(op_sub, 4'd12, 4'd3, 4'd2, 16'h0000, idx);
    drain();
  endtask

  task automatic hazard_stall();
    int mul_idx;
    int idx;
    send(op_li, 4'd1, 4'd0, 4'd0, 16'h1234, idx);
    send(op_li, 4'd2, 4'd0, 4'd0, 16'hff00, idx);
    send(op_mul, 4'd5, 4'd1, 4'd2, 16'h0000, mul_idx);
    send(op_add, 4'd6, 4'd5, 4'd1, 16'h0000, idx);
    if (!timed_out && commit_count <= mul_idx) begin
      $display("the add reading r5 was accepted before the multiply writing r5 committed");
      check_errors++;
    end
    drain();
  endtask

  task automatic mixed_stream();
    int idx;
    op_t op;
    for (int i = 0; i < 200; i++) begin
      op = ($urandom_range(3, 0) == 0) ? op_mul : random_alu_op();
      send(op, reg_idx_t'($urandom_range(15, 0)), reg_idx_t'($urandom_range(15, 0)),
           reg_idx_t'($urandom_range(15, 0)), imm_t'($urandom), idx);
    end
    drain();
    if (!timed_out && commit_count != accepted) begin
      $display("%0d instructions were accepted but %0d committed", accepted, commit_count);
      check_errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before, input string note);
    int errs;
    errs = total_errors() - errs_before;
    if (timed_out) begin
      tests_failed++;
      $display("%s: fail, stopped by a timeout", name);
    end else if (errs != 0) begin
      tests_failed++;
      $display("%s: fail with %0d errors%s", name, errs, note);
    end else begin
      tests_passed++;
      $display("%s: pass%s", name, note);
    end
  endtask

  initial begin
    int err0;
    void'($urandom(SEED));
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr_op    = op_li;
    instr_rd    = '0;
    instr_rs1   = '0;
    instr_rs2   = '0;
    instr_imm   = '0;
    for (int r = 0; r < `REG_COUNT; r++) model_regs[r] = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    err0 = total_errors();
    load_readback();
    report_test("test 1 load and read back", err0, "");
    err0 = total_errors();
    alu_ops();
    report_test("test 2 alu operations", err0, "");
    err0 = total_errors();
    ooo_commit();
    report_test("test 3 out-of-order completion", err0, "");
    err0 = total_errors();
    hazard_stall();
    report_test("test 4 hazard stall", err0, "");
    err0 = total_errors();
    peak_in_flight = 0;
    mixed_stream();
    report_test("test 5 mixed stream", err0, $sformatf(", peak %0d in flight", peak_in_flight));

    $display("%0d tests passed, %0d failed, %0d commits checked, %0d errors",
             tests_passed, tests_failed, commit_count, total_errors());
    if (total_errors() == 0 && tests_failed == 0 && !timed_out) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module alu_unit import core_pkg::*; (
  input logic clk,
  input logic reset,
  dispatch_if.unit dispatch,
  cdb_if.alu cdb
);

  localparam int SHAMT_W = $clog2(`XLEN);

  word_t result;

  always_comb begin
    case (dispatch.op)
      op_li:   result = dispatch.b; // issue already placed the immediate in b.
      op_addi: result = dispatch.a + dispatch.b;
      op_add:  result = dispatch.a + dispatch.b;
      op_sub:  result = dispatch.a - dispatch.b;
      op_and:  result = dispatch.a & dispatch.b;
      op_or:   result = dispatch.a | dispatch.b;
      op_xor:  result = dispatch.a ^ dispatch.b;
      op_slt:  result = {{(`XLEN-1){1'b0}}, $signed(dispatch.a) < $signed(dispatch.b)};
      op_sll:  result = dispatch.a << dispatch.b[SHAMT_W-1:0];
      op_srl:  result = dispatch.a >> dispatch.b[SHAMT_W-1:0];
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) cdb.alu_valid <= 1'b0;
    else cdb.alu_valid <= dispatch.valid;
    cdb.alu_result <= '{tag: dispatch.tag, value: result};
  end

  a_no_mul: assert property (@(posedge clk) disable iff (reset)
    dispatch.valid |-> dispatch.op != op_mul);

endmodule

`default_nettype wire

// ==== design/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// one instance per functional unit. valid is a single cycle strobe.
interface dispatch_if import core_pkg::*; ();

  logic     valid;
  op_t      op;
  word_t    a;
  word_t    b;
  rob_tag_t tag;

  modport issue(output valid, output op, output a, output b, output tag);

  modport unit(input valid, input op, input a, input b, input tag);

endinterface

// shared result bus. each unit owns its own valid and result pair.
interface cdb_if import core_pkg::*; ();

  logic    alu_valid;
  result_t alu_result;
  logic    mult_valid;
  result_t mult_result;

  modport alu(output alu_valid, output alu_result);

  modport mult(output mult_valid, output mult_result);

  modport rob(
    input alu_valid,
    input alu_result,
    input mult_valid,
    input mult_result
  );

endinterface

`default_nettype wire

// ==== design/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data path width in bits.
`define XLEN 32

// architectural registers, register 0 is hardwired to zero.
`define REG_COUNT 16

// in-flight instructions tracked by the reorder buffer.
// must stay a power of two, the pointers wrap naturally.
`define ROB_DEPTH 8

`endif

// ==== design/core_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package core_pkg;

  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
  typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_tag_t;
  typedef logic [`XLEN-1:0] word_t;
  typedef logic [15:0] imm_t; // raw immediate from decode.

  typedef enum logic [3:0] {
    op_li,
    op_addi,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_slt,
    op_sll,
    op_srl,
    op_mul
  } op_t;

  typedef struct packed {
    op_t      op;
    word_t    a;
    word_t    b;
    rob_tag_t tag;
  } dispatch_t;

  typedef struct packed {
    rob_tag_t tag;
    word_t    value;
  } result_t;

endpackage

`default_nettype wire

// ==== design/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  op_t      instr_op,
  input  reg_idx_t instr_rd,
  input  reg_idx_t instr_rs1,
  input  reg_idx_t instr_rs2,
  input  imm_t     instr_imm,
  output logic     instr_ready,
  output logic     commit_valid,
  output reg_idx_t commit_rd,
  output word_t    commit_value
);

  dispatch_if alu_dispatch ();
  dispatch_if mult_dispatch ();
  cdb_if      cdb ();

  reg_idx_t rs1, rs2;
  word_t    rs1_value, rs2_value;
  logic     rs1_pending, rs2_pending;
  logic     alloc_valid;
  reg_idx_t alloc_rd;
  logic     rob_full;
  rob_tag_t rob_tail; // doubles as the tag of the instruction being accepted.
  rob_tag_t commit_tag;

  register_file register_file (
    .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .alloc_tag(rob_tail),
    .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_tag(commit_tag), .commit_value(commit_value),
    .rs1_value(rs1_value), .rs2_value(rs2_value),
    .rs1_pending(rs1_pending), .rs2_pending(rs2_pending)
  );

  issue_stage issue_stage (
    .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr_op(instr_op),
    .instr_rd(instr_rd), .instr_rs1(instr_rs1), .instr_rs2(instr_rs2),
    .instr_imm(instr_imm), .rs1_value(rs1_value), .rs2_value(rs2_value),
    .rs1_pending(rs1_pending), .rs2_pending(rs2_pending),
    .rob_full(rob_full), .rob_tail(rob_tail), .instr_ready(instr_ready),
    .alloc_valid(alloc_valid), .alloc_rd(alloc_rd), .rs1(rs1), .rs2(rs2),
    .alu(alu_dispatch), .mult(mult_dispatch)
  );

  alu_unit alu_unit (.clk(clk), .reset(reset), .dispatch(alu_dispatch), .cdb(cdb));

  mult_unit mult_unit (.clk(clk), .reset(reset), .dispatch(mult_dispatch), .cdb(cdb));

  reorder_buffer reorder_buffer (
    .clk(clk), .reset(reset), .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
    .cdb(cdb), .rob_full(rob_full), .rob_tail(rob_tail),
    .commit_valid(commit_valid), .commit_rd(commit_rd),
    .commit_tag(commit_tag), .commit_value(commit_value)
  );

endmodule

`default_nettype wire

// ==== design/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module issue_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     instr_valid,
  input  op_t      instr_op,
  input  reg_idx_t instr_rd,
  input  reg_idx_t instr_rs1,
  input  reg_idx_t instr_rs2,
  input  imm_t     instr_imm,
  input  word_t    rs1_value,
  input  word_t    rs2_value,
  input  logic     rs1_pending,
  input  logic     rs2_pending,
  input  logic     rob_full,
  input  rob_tag_t rob_tail,
  output logic     instr_ready,
  output logic     alloc_valid,
  output reg_idx_t alloc_rd,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  dispatch_if.issue alu,
  dispatch_if.issue mult
);

  logic      uses_rs1;
  logic      uses_rs2;
  logic      is_mul;
  logic      accept;
  logic      slot_clash;
  logic [3:0] need_slot;
  logic [3:0] slot_busy; // bit k is the bus cycle k cycles after a dispatch issued now.
  word_t     imm_ext;
  word_t     op_a;
  word_t     op_b;
  logic      alu_valid_q;
  logic      mult_valid_q;
  dispatch_t disp_q;

  assign rs1      = instr_rs1;
  assign rs2      = instr_rs2;
  assign alloc_rd = instr_rd;

  assign uses_rs1  = instr_op != op_li;
  assign uses_rs2  = !(instr_op inside {op_li, op_addi});
  assign is_mul    = instr_op == op_mul;
  assign need_slot = is_mul ? 4'b1000 : 4'b0010; // alu finishes 1 cycle after dispatch, mult 3.

  assign slot_clash  = |(slot_busy & need_slot);
  assign instr_ready = !rob_full && !slot_clash &&
                       !(uses_rs1 && rs1_pending) && !(uses_rs2 && rs2_pending);
  assign accept      = instr_valid && instr_ready;
  assign alloc_valid = accept;

  assign imm_ext = {{(`XLEN - $bits(imm_t)){instr_imm[$bits(imm_t)-1]}}, instr_imm};
  assign op_a    = uses_rs1 ? rs1_value : '0;
  assign op_b    = uses_rs2 ? rs2_value : imm_ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_valid_q  <= 1'b0;
      mult_valid_q <= 1'b0;
      slot_busy    <= '0;
    end else begin
      alu_valid_q  <= accept && !is_mul;
      mult_valid_q <= accept && is_mul;
      slot_busy    <= (slot_busy | (accept ? need_slot : 4'b0000)) >> 1;
    end
    if (accept) begin
      disp_q <= '{op: instr_op, a: op_a, b: op_b, tag: rob_tail};
    end
  end

  // both units see the same payload, only the strobe selects the target.
  assign alu.valid  = alu_valid_q;
  assign alu.op     = disp_q.op;
  assign alu.a      = disp_q.a;
  assign alu.b      = disp_q.b;
  assign alu.tag    = disp_q.tag;
  assign mult.valid = mult_valid_q;
  assign mult.op    = disp_q.op;
  assign mult.a     = disp_q.a;
  assign mult.b     = disp_q.b;
  assign mult.tag   = disp_q.tag;

  // an alu dispatch two cycles after a multiply would land on the multiply's bus cycle.
  a_bus_slot: assert property (@(posedge clk) disable iff (reset)
    alu.valid |-> !$past(mult.valid, 2));

endmodule

`default_nettype wire

// ==== design/mult_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module mult_unit import core_pkg::*; (
  input logic clk,
  input logic reset,
  dispatch_if.unit dispatch,
  cdb_if.mult cdb
);

  localparam int HALF = `XLEN / 2;

  word_t           ll_full;
  word_t           lh_full;
  word_t           hl_full;
  word_t           p_ll;
  logic [HALF-1:0] p_lh; // cross terms only matter below bit XLEN after the shift.
  logic [HALF-1:0] p_hl;
  logic            s1_valid;
  rob_tag_t        s1_tag;
  word_t           s2_value;
  logic            s2_valid;
  rob_tag_t        s2_tag;

  // the high by high product lands entirely above the low word and is never formed.
  assign ll_full = word_t'(dispatch.a[HALF-1:0]) * word_t'(dispatch.b[HALF-1:0]);
  assign lh_full = word_t'(dispatch.a[HALF-1:0]) * word_t'(dispatch.b[`XLEN-1:HALF]);
  assign hl_full = word_t'(dispatch.a[`XLEN-1:HALF]) * word_t'(dispatch.b[HALF-1:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid       <= 1'b0;
      s2_valid       <= 1'b0;
      cdb.mult_valid <= 1'b0;
    end else begin
      s1_valid       <= dispatch.valid;
      s2_valid       <= s1_valid;
      cdb.mult_valid <= s2_valid;
    end
    p_ll            <= ll_full;
    p_lh            <= lh_full[HALF-1:0];
    p_hl            <= hl_full[HALF-1:0];
    s1_tag          <= dispatch.tag;
    s2_value        <= p_ll + {p_lh + p_hl, {HALF{1'b0}}}; // carry out of the cross sum drops.
    s2_tag          <= s1_tag;
    cdb.mult_result <= '{tag: s2_tag, value: s2_value};
  end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module register_file import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  logic     alloc_valid,
  input  reg_idx_t alloc_rd,
  input  rob_tag_t alloc_tag,
  input  logic     commit_valid,
  input  reg_idx_t commit_rd,
  input  rob_tag_t commit_tag,
  input  word_t    commit_value,
  output word_t    rs1_value,
  output word_t    rs2_value,
  output logic     rs1_pending,
  output logic     rs2_pending
);

  word_t                 regs[`REG_COUNT];
  logic [`REG_COUNT-1:0] pending;
  rob_tag_t              pend_tag[`REG_COUNT]; // youngest writer of each register.

  // no bypass from commit, a register committing this cycle still reads as pending.
  assign rs1_value   = regs[rs1];
  assign rs2_value   = regs[rs2];
  assign rs1_pending = pending[rs1];
  assign rs2_pending = pending[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      pending <= '0;
    end else begin
      if (commit_valid && commit_rd != '0) begin
        regs[commit_rd] <= commit_value;
      end
      // only the recorded writer releases the register.
      if (commit_valid && pending[commit_rd] && pend_tag[commit_rd] == commit_tag) begin
        pending[commit_rd] <= 1'b0;
      end
      if (alloc_valid && alloc_rd != '0) begin
        pending[alloc_rd] <= 1'b1; // a new allocation overrides a release in the same cycle.
      end
    end
    if (alloc_valid && alloc_rd != '0) begin
      pend_tag[alloc_rd] <= alloc_tag;
    end
  end

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module reorder_buffer import core_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     alloc_valid,
  input  reg_idx_t alloc_rd,
  cdb_if.rob       cdb,
  output logic     rob_full,
  output rob_tag_t rob_tail,
  output logic     commit_valid,
  output reg_idx_t commit_rd,
  output rob_tag_t commit_tag,
  output word_t    commit_value
);

  localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;
  localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`ROB_DEPTH);

  reg_idx_t              entry_rd[`ROB_DEPTH];
  word_t                 entry_value[`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] entry_done;
  rob_tag_t              head;
  rob_tag_t              tail;
  logic [CNT_W-1:0]      count;
  logic                  cdb_hit;
  result_t               cdb_sel;
  logic                  commit_fire;
  logic [CNT_W-1:0]      cdb_offset;

  // at most one unit drives the bus in a cycle, so a plain select is enough.
  assign cdb_hit = cdb.alu_valid || cdb.mult_valid;
  assign cdb_sel = cdb.alu_valid ? cdb.alu_result : cdb.mult_result;

  assign rob_full    = count == FULL_COUNT;
  assign rob_tail    = tail;
  assign commit_fire = count != '0 && entry_done[head];
  assign cdb_offset  = {1'b0, rob_tag_t'(cdb_sel.tag - head)};

  always_ff @(posedge clk) begin
    if (reset) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      entry_done   <= '0;
      commit_valid <= 1'b0;
    end else begin
      if (alloc_valid) begin
        entry_done[tail] <= 1'b0;
        tail             <= tail + 1'b1;
      end
      if (cdb_hit) entry_done[cdb_sel.tag] <= 1'b1;
      if (commit_fire) head <= head + 1'b1;
      count        <= count + CNT_W'(alloc_valid) - CNT_W'(commit_fire);
      commit_valid <= commit_fire;
    end
    if (alloc_valid) entry_rd[tail] <= alloc_rd;
    if (cdb_hit) entry_value[cdb_sel.tag] <= cdb_sel.value;
    commit_rd  <= entry_rd[head];
    commit_tag <= head;
    // register 0 commits as zero whatever the unit produced.
    commit_value <= (entry_rd[head] == '0) ? '0 : entry_value[head];
  end

  a_one_result: assert property (@(posedge clk) disable iff (reset)
    !(cdb.alu_valid && cdb.mult_valid));

  a_tag_occupied: assert property (@(posedge clk) disable iff (reset)
    cdb_hit |-> cdb_offset < count);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# builds the exec_core testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module exec_core_tb -o exec_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/exec_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the verdict.
if grep -q -F '*** PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== src.f ====
+incdir+design
design/core_pkg.sv
design/core_ifs.sv
design/register_file.sv
design/issue_stage.sv
design/alu_unit.sv
design/mult_unit.sv
design/reorder_buffer.sv
design/exec_core.sv
bench/exec_core_tb.sv
